//--- Makefile
# Verilator build and run for the GF(3^194) multiplier

VERILATOR  ?= verilator
TOP        ?= gf9m_mult_tb
RTL_TOP    ?= gf9m_mult_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= hw/gf3_pkg.sv hw/gf_stream_if.sv hw/karatsuba_split.sv \
              hw/gf3m_serial_mult.sv hw/karatsuba_join.sv hw/gf9m_mult_top.sv
SIM_BIN    := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(FILELIST) $(wildcard hw/*.sv verification/*.sv verification/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/gf3_pkg.sv
`default_nettype none

package gf3_pkg;

    localparam int FIELD_M = 97;   // p(x) = x^97 + x^12 + 2
    localparam int TAP_POS = 12;

    typedef enum logic [1:0] {
        TRIT_ZERO = 2'b00,
        TRIT_ONE  = 2'b01,
        TRIT_TWO  = 2'b10
    } trit_t;

    typedef logic [2*FIELD_M-1:0] gf3m_t;   // trit 0 in bits [1:0]
    typedef logic [4*FIELD_M-1:0] gf9m_t;   // {high half, low half}

    typedef enum logic [1:0] {
        PROD_LOW,    // a0*b0
        PROD_HIGH,   // a1*b1
        PROD_SUM     // (a0+a1)*(b0+b1)
    } prod_sel_t;

    typedef enum logic [1:0] {
        MULT_IDLE,
        MULT_RUN,
        MULT_HOLD
    } mult_state_t;

    function automatic trit_t trit_add(trit_t a, trit_t b);
        logic [2:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 3'd3)
            s = s - 3'd3;
        return trit_t'(s[1:0]);
    endfunction

    function automatic trit_t trit_neg(trit_t a);
        return trit_t'({a[0], a[1]});   // 1 <-> 2, 0 stays
    endfunction

    function automatic trit_t trit_mul(trit_t a, trit_t b);
        if (a == TRIT_ZERO || b == TRIT_ZERO)
            return TRIT_ZERO;
        return (a == b) ? TRIT_ONE : TRIT_TWO;
    endfunction

    function automatic gf3m_t elem_add(gf3m_t a, gf3m_t b);
        gf3m_t r;
        for (int i = 0; i < FIELD_M; i++)
            r[2*i +: 2] = trit_add(trit_t'(a[2*i +: 2]), trit_t'(b[2*i +: 2]));
        return r;
    endfunction

    function automatic gf3m_t elem_sub(gf3m_t a, gf3m_t b);
        gf3m_t r;
        for (int i = 0; i < FIELD_M; i++)
            r[2*i +: 2] = trit_add(trit_t'(a[2*i +: 2]), trit_neg(trit_t'(b[2*i +: 2])));
        return r;
    endfunction

    function automatic gf3m_t elem_scale(gf3m_t a, trit_t t);
        gf3m_t r;
        for (int i = 0; i < FIELD_M; i++)
            r[2*i +: 2] = trit_mul(trit_t'(a[2*i +: 2]), t);
        return r;
    endfunction

    // multiply by x mod p where the trit leaving degree 96 returns as 2x^12 + 1
    function automatic gf3m_t elem_mulx(gf3m_t a);
        trit_t top;
        gf3m_t r;
        top = trit_t'(a[2*FIELD_M-1 -: 2]);
        r = {a[2*FIELD_M-3:0], 2'b00};
        r[1:0] = top;
        r[2*TAP_POS +: 2] = trit_add(trit_t'(r[2*TAP_POS +: 2]), trit_neg(top));
        return r;
    endfunction

endpackage

`default_nettype wire

//--- hw/gf3m_serial_mult.sv
`timescale 1ns/1ps
`default_nettype none

// digit-serial multiplier in GF(3^97), DIGITS trits of y per cycle
module gf3m_serial_mult #(
    parameter int DIGITS = 3
) (
    input  logic    clk,
    input  logic    reset,
    operand_if.dst  opnd,
    product_if.src  prod
);

    localparam int ITERATIONS = (gf3_pkg::FIELD_M + DIGITS - 1) / DIGITS;
    localparam int CNT_W      = $clog2(ITERATIONS + 1);

    gf3_pkg::mult_state_t  state;
    gf3_pkg::prod_sel_t    sel_q;
    logic [CNT_W-1:0]      count_q;
    gf3_pkg::gf3m_t        x_q;
    gf3_pkg::gf3m_t        y_q;
    gf3_pkg::gf3m_t        z_q;
    gf3_pkg::gf3m_t        x_pow [DIGITS+1];
    gf3_pkg::gf3m_t        z_sum;
    logic                  opnd_fire;
    logic                  prod_fire;

    assign opnd.ready = (state == gf3_pkg::MULT_IDLE);
    assign opnd_fire  = opnd.valid && opnd.ready;

    assign prod.valid = (state == gf3_pkg::MULT_HOLD);
    assign prod.sel   = sel_q;
    assign prod.p     = z_q;
    assign prod_fire  = prod.valid && prod.ready;

    // x_pow[j] = x * x^j mod p
    always_comb
    begin
        x_pow[0] = x_q;
        z_sum    = z_q;
        for (int j = 0; j < DIGITS; j++)
        begin
            z_sum = gf3_pkg::elem_add(z_sum,
                        gf3_pkg::elem_scale(x_pow[j], gf3_pkg::trit_t'(y_q[2*j +: 2])));
            x_pow[j+1] = gf3_pkg::elem_mulx(x_pow[j]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= gf3_pkg::MULT_IDLE;
            count_q <= '0;
        end
        else
        begin
            case (state)
                gf3_pkg::MULT_IDLE:
                begin
                    if (opnd_fire)
                    begin
                        state   <= gf3_pkg::MULT_RUN;
                        count_q <= CNT_W'(ITERATIONS - 1);
                    end
                end
                gf3_pkg::MULT_RUN:
                begin
                    if (count_q == '0)
                        state <= gf3_pkg::MULT_HOLD;
                    else
                        count_q <= count_q - 1'b1;
                end
                gf3_pkg::MULT_HOLD:
                begin
                    if (prod_fire)
                        state <= gf3_pkg::MULT_IDLE;   // stalls here while join is full
                end
                default:
                    state <= gf3_pkg::MULT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (opnd_fire)
        begin
            x_q   <= opnd.x;
            y_q   <= opnd.y;
            z_q   <= '0;
            sel_q <= opnd.sel;
        end
        else if (state == gf3_pkg::MULT_RUN)
        begin
            x_q <= x_pow[DIGITS];
            y_q <= y_q >> (2*DIGITS);   // next digit group
            z_q <= z_sum;
        end
    end

endmodule

`default_nettype wire

//--- hw/gf9m_mult_top.sv
`timescale 1ns/1ps
`default_nettype none

module gf9m_mult_top #(
    parameter int DIGITS = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req_valid,
    output logic             req_ready,
    input  gf3_pkg::gf9m_t   req_a,
    input  gf3_pkg::gf9m_t   req_b,
    output logic             res_valid,
    input  logic             res_ready,
    output gf3_pkg::gf9m_t   res_c
);

    operand_if  opnd_bus ();
    product_if  prod_bus ();

    karatsuba_split u_split (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_a     (req_a),
        .req_b     (req_b),
        .req_ready (req_ready),
        .opnd      (opnd_bus.src)
    );

    gf3m_serial_mult #(
        .DIGITS (DIGITS)
    ) u_mult (
        .clk   (clk),
        .reset (reset),
        .opnd  (opnd_bus.dst),
        .prod  (prod_bus.src)
    );

    karatsuba_join u_join (
        .clk       (clk),
        .reset     (reset),
        .prod      (prod_bus.dst),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_c     (res_c)
    );

endmodule

`default_nettype wire

//--- hw/gf_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// operand pairs from the split stage to the serial multiplier
interface operand_if;
    logic                valid;
    logic                ready;
    gf3_pkg::prod_sel_t  sel;
    gf3_pkg::gf3m_t      x;
    gf3_pkg::gf3m_t      y;

    modport src (
        output valid,
        output sel,
        output x,
        output y,
        input  ready
    );

    modport dst (
        input  valid,
        input  sel,
        input  x,
        input  y,
        output ready
    );
endinterface

// tagged products from the multiplier to the join stage
interface product_if;
    logic                valid;
    logic                ready;
    gf3_pkg::prod_sel_t  sel;
    gf3_pkg::gf3m_t      p;

    modport src (output valid, output sel, output p, input ready);
    modport dst (input valid, input sel, input p, output ready);
endinterface

`default_nettype wire

//--- hw/karatsuba_join.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_join (
    input  logic             clk,
    input  logic             reset,
    product_if.dst           prod,
    output logic             res_valid,
    input  logic             res_ready,
    output gf3_pkg::gf9m_t   res_c
);

    logic [1:0]      slot_count;
    gf3_pkg::gf3m_t  low_q;
    gf3_pkg::gf3m_t  high_q;
    gf3_pkg::gf3m_t  sum_q;
    gf3_pkg::gf3m_t  c0;
    gf3_pkg::gf3m_t  c1;
    logic            prod_fire;
    logic            res_fire;

    assign prod.ready = (slot_count != 2'd3);
    assign prod_fire  = prod.valid && prod.ready;

    assign res_valid = (slot_count == 2'd3);
    assign res_fire  = res_valid && res_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            slot_count <= 2'd0;
        else if (res_fire)
            slot_count <= 2'd0;   // all three slots free again
        else if (prod_fire)
            slot_count <= slot_count + 2'd1;
    end

    always_ff @(posedge clk)
    begin
        if (prod_fire)
        begin
            case (prod.sel)
                gf3_pkg::PROD_LOW:  low_q  <= prod.p;
                gf3_pkg::PROD_HIGH: high_q <= prod.p;
                default:            sum_q  <= prod.p;
            endcase
        end
    end

    // y^2 = -1 folds a1*b1 into the low half
    assign c0 = gf3_pkg::elem_sub(low_q, high_q);
    assign c1 = gf3_pkg::elem_sub(gf3_pkg::elem_sub(sum_q, low_q), high_q);

    assign res_c = {c1, c0};

endmodule

`default_nettype wire

//--- hw/karatsuba_split.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_split (
    input  logic             clk,
    input  logic             reset,
    input  logic             req_valid,
    input  gf3_pkg::gf9m_t   req_a,
    input  gf3_pkg::gf9m_t   req_b,
    output logic             req_ready,
    operand_if.src           opnd
);

    logic                busy;
    gf3_pkg::prod_sel_t  sel_q;
    gf3_pkg::gf9m_t      a_q;
    gf3_pkg::gf9m_t      b_q;
    gf3_pkg::gf3m_t      a0;
    gf3_pkg::gf3m_t      a1;
    gf3_pkg::gf3m_t      b0;
    gf3_pkg::gf3m_t      b1;
    logic                req_fire;
    logic                opnd_fire;

    assign req_ready = !busy;
    assign req_fire  = req_valid && req_ready;
    assign opnd_fire = opnd.valid && opnd.ready;

    assign {a1, a0} = a_q;
    assign {b1, b0} = b_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            sel_q <= gf3_pkg::PROD_LOW;
        end
        else if (req_fire)
        begin
            busy  <= 1'b1;
            sel_q <= gf3_pkg::PROD_LOW;
        end
        else if (opnd_fire)
        begin
            case (sel_q)
                gf3_pkg::PROD_LOW:  sel_q <= gf3_pkg::PROD_HIGH;
                gf3_pkg::PROD_HIGH: sel_q <= gf3_pkg::PROD_SUM;
                default:            busy  <= 1'b0;   // last pair gone
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            a_q <= req_a;
            b_q <= req_b;
        end
    end

    assign opnd.valid = busy;
    assign opnd.sel   = sel_q;

    always_comb
    begin
        case (sel_q)
            gf3_pkg::PROD_HIGH:
            begin
                opnd.x = a1;
                opnd.y = b1;
            end
            gf3_pkg::PROD_SUM:
            begin
                opnd.x = gf3_pkg::elem_add(a0, a1);   // half sums for the middle term
                opnd.y = gf3_pkg::elem_add(b0, b1);
            end
            default:
            begin
                opnd.x = a0;
                opnd.y = b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verification/gf9m_mult_props.sv
`timescale 1ns/1ps
`default_nettype none

module gf9m_mult_props (
    input  logic                clk,
    input  logic                reset,
    input  logic                res_valid,
    input  logic                res_ready,
    input  gf3_pkg::gf9m_t      res_c,
    input  logic                prod_valid,
    input  logic                prod_ready,
    input  gf3_pkg::prod_sel_t  prod_sel,
    input  gf3_pkg::gf3m_t      prod_p
);

    res_held: assert property (@(posedge clk) disable iff (reset)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_c)))
        else $error("result changed or dropped while waiting for res_ready");

    prod_held: assert property (@(posedge clk) disable iff (reset)
        (prod_valid && !prod_ready) |=> (prod_valid && $stable(prod_p) && $stable(prod_sel)))
        else $error("product changed or dropped while join was full");

    res_reset: assert property (@(posedge clk) reset |=> !res_valid)
        else $error("res_valid high in the cycle after reset");

endmodule

bind karatsuba_join gf9m_mult_props u_props (
    .clk        (clk),
    .reset      (reset),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_c      (res_c),
    .prod_valid (prod.valid),
    .prod_ready (prod.ready),
    .prod_sel   (prod.sel),
    .prod_p     (prod.p)
);

`default_nettype wire

//--- verification/gf9m_ref.svh
`ifndef GF9M_REF_SVH
`define GF9M_REF_SVH

// schoolbook product in GF(3^97), reduced with x^97 = 2x^12 + 1
function automatic gf3_pkg::gf3m_t ref_gf3m_mult(input gf3_pkg::gf3m_t a,
                                                 input gf3_pkg::gf3m_t b);
    int acc [2*gf3_pkg::FIELD_M-1];
    gf3_pkg::gf3m_t r;
    foreach (acc[k])
        acc[k] = 0;
    for (int i = 0; i < gf3_pkg::FIELD_M; i++)
        for (int j = 0; j < gf3_pkg::FIELD_M; j++)
            acc[i+j] = (acc[i+j] + int'(a[2*i +: 2]) * int'(b[2*j +: 2])) % 3;
    for (int k = 2*gf3_pkg::FIELD_M-2; k >= gf3_pkg::FIELD_M; k--)
    begin
        acc[k-gf3_pkg::FIELD_M] = (acc[k-gf3_pkg::FIELD_M] + acc[k]) % 3;
        acc[k-gf3_pkg::FIELD_M+gf3_pkg::TAP_POS] =
            (acc[k-gf3_pkg::FIELD_M+gf3_pkg::TAP_POS] + 2*acc[k]) % 3;
        acc[k] = 0;
    end
    for (int i = 0; i < gf3_pkg::FIELD_M; i++)
        r[2*i +: 2] = 2'(acc[i]);
    return r;
endfunction

// four half products, combined with y^2 = -1
function automatic gf3_pkg::gf9m_t ref_gf9m_mult(input gf3_pkg::gf9m_t a,
                                                 input gf3_pkg::gf9m_t b);
    gf3_pkg::gf3m_t a0;
    gf3_pkg::gf3m_t a1;
    gf3_pkg::gf3m_t b0;
    gf3_pkg::gf3m_t b1;
    gf3_pkg::gf3m_t c0;
    gf3_pkg::gf3m_t c1;
    {a1, a0} = a;
    {b1, b0} = b;
    c0 = gf3_pkg::elem_sub(ref_gf3m_mult(a0, b0), ref_gf3m_mult(a1, b1));
    c1 = gf3_pkg::elem_add(ref_gf3m_mult(a0, b1), ref_gf3m_mult(a1, b0));
    return {c1, c0};
endfunction

`endif

//--- verification/gf9m_mult_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gf9m_mult_tb;

    localparam int DIGITS         = 3;
    localparam int ITERATIONS     = (gf3_pkg::FIELD_M + DIGITS - 1) / DIGITS;
    localparam int ROWS           = 8;
    localparam int RESET_CYCLES   = 2;
    localparam int TIMEOUT_CYCLES = ROWS * 4 * 3 * (ITERATIONS + 2) + RESET_CYCLES;

    logic            clk;
    logic            reset;
    logic            req_valid;
    logic            req_ready;
    gf3_pkg::gf9m_t  req_a;
    gf3_pkg::gf9m_t  req_b;
    logic            res_valid;
    logic            res_ready;
    gf3_pkg::gf9m_t  res_c;

    gf3_pkg::gf9m_t  tab_a    [ROWS];
    gf3_pkg::gf9m_t  tab_b    [ROWS];
    gf3_pkg::gf9m_t  tab_exp  [ROWS];
    bit              tab_rand [ROWS];   // expected value comes from the model
    string           tab_name [ROWS];
    logic [15:0]     lfsr_q;
    int              rx_count    = 0;
    int              error_count = 0;
    int              pass_rows   = 0;
    int              cycle_count = 0;

    `include "gf9m_ref.svh"

    gf9m_mult_top #(
        .DIGITS (DIGITS)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_a     (req_a),
        .req_b     (req_b),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_c     (res_c)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
    endfunction

    function logic lfsr_bit();
        lfsr_bit = lfsr_q[0];
        lfsr_q   = lfsr_next(lfsr_q);
    endfunction

    function gf3_pkg::gf9m_t random_elem();
        gf3_pkg::gf9m_t r;
        logic           hi;
        logic           lo;
        for (int i = 0; i < 2*gf3_pkg::FIELD_M; i++)
        begin
            hi = lfsr_bit();
            lo = lfsr_bit();
            r[2*i +: 2] = ({hi, lo} == 2'b11) ? 2'b00 : {hi, lo};   // 3 wraps to 0
        end
        return r;
    endfunction

    task automatic fill_table();
        tab_name[0] = "identity";
        tab_rand[0] = 1'b0;
        tab_a[0]    = {{97{2'b10}}, {97{2'b01}}};
        tab_b[0]    = {gf3_pkg::gf3m_t'(0), gf3_pkg::gf3m_t'(1)};
        tab_exp[0]  = {{97{2'b10}}, {97{2'b01}}};
        tab_name[1] = "y squared";
        tab_rand[1] = 1'b0;
        tab_a[1]    = {gf3_pkg::gf3m_t'(1), gf3_pkg::gf3m_t'(0)};
        tab_b[1]    = {gf3_pkg::gf3m_t'(1), gf3_pkg::gf3m_t'(0)};
        tab_exp[1]  = {gf3_pkg::gf3m_t'(0), gf3_pkg::gf3m_t'(2)};   // -1
        tab_name[2] = "x^96 times x";
        tab_rand[2] = 1'b0;
        tab_a[2]    = {gf3_pkg::gf3m_t'(0), gf3_pkg::gf3m_t'(1) << 192};
        tab_b[2]    = {gf3_pkg::gf3m_t'(0), gf3_pkg::gf3m_t'(4)};
        tab_exp[2]  = {gf3_pkg::gf3m_t'(0), (gf3_pkg::gf3m_t'(2) << 24) | gf3_pkg::gf3m_t'(1)};
        for (int i = 3; i < ROWS; i++)
        begin
            tab_name[i] = "random";
            tab_rand[i] = 1'b1;
            tab_a[i]    = random_elem();
            tab_b[i]    = random_elem();
        end
        for (int i = 0; i < ROWS; i++)
        begin
            if (tab_rand[i])
                tab_exp[i] = ref_gf9m_mult(tab_a[i], tab_b[i]);
        end
    endtask

    task automatic check_result(input int idx);
        int errs_before;
        errs_before = error_count;
        assert (res_c === tab_exp[idx])
        else
        begin
            $display("Mismatch at %0t: row %0d (%s) gave %h expected %h",
                     $time, idx, tab_name[idx], res_c, tab_exp[idx]);
            error_count++;
        end
        if (error_count == errs_before)
            pass_rows++;
        $display("row %0d %s: %s", idx, tab_name[idx],
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure on the result side
    initial
    begin
        res_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            res_ready <= reset ? 1'b0 : lfsr_bit();
        end
    end

    always @(negedge clk)
    begin
        if (!reset && res_valid && res_ready)
        begin
            assert (rx_count < ROWS)
            else
            begin
                $display("an extra result arrived after all rows were done");
                error_count++;
            end
            if (rx_count < ROWS)
                check_result(rx_count);
            rx_count++;
        end
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: only %0d of %0d results arrived", rx_count, ROWS);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_a     = '0;
        req_b     = '0;
        lfsr_q    = 16'd62165;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!res_valid && req_ready)
        else
        begin
            $display("res_valid high or req_ready low right after reset");
            error_count++;
        end
        for (int i = 0; i < ROWS; i++)
        begin
            @(posedge clk);
            req_valid <= 1'b1;
            req_a     <= tab_a[i];
            req_b     <= tab_b[i];
            do
                @(negedge clk);
            while (!req_ready);   // taken on the coming edge
        end
        @(posedge clk);
        req_valid <= 1'b0;
        wait (rx_count == ROWS);
        @(negedge clk);
        assert (!res_valid)
        else
        begin
            $display("res_valid still high after the last result was taken");
            error_count++;
        end
        $display("rows %0d, passed %0d, failed %0d, errors %0d",
                 ROWS, pass_rows, ROWS - pass_rows, error_count);
        if (error_count == 0 && pass_rows == ROWS)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
hw/gf3_pkg.sv
hw/gf_stream_if.sv
hw/karatsuba_split.sv
hw/gf3m_serial_mult.sv
hw/karatsuba_join.sv
hw/gf9m_mult_top.sv
verification/gf9m_mult_props.sv
verification/gf9m_mult_tb.sv
